//--- alu_pkg.sv
`default_nettype none

package alu_pkg;

	// datapath widths.
	localparam int WORD_W  = 16;
	localparam int SHAMT_W = 4;
	localparam int OP_W    = 2;
	localparam int FLAG_W  = 3;

	// operands, sums, shifted values and registered results all share this type.
	typedef logic [WORD_W-1:0] word_t;

	// shift distance, one bit per mux stage of the shifter.
	typedef logic [SHAMT_W-1:0] shamt_t;

	typedef logic [OP_W-1:0] alu_op_t;

	// opcode encoding.
	localparam alu_op_t OP_ADD = 2'd0;
	localparam alu_op_t OP_SUB = 2'd1;
	localparam alu_op_t OP_SLL = 2'd2; // logical left, zero fill.
	localparam alu_op_t OP_SRA = 2'd3; // arithmetic right, sign fill.

	// condition flags, indexed by the positions below.
	typedef logic [FLAG_W-1:0] flags_t;

	localparam int FLAG_Z = 0; // result is zero.
	localparam int FLAG_V = 1; // last add or subtract saturated.
	localparam int FLAG_N = 2; // sign of the last add or subtract.

	// signed saturation limits of a word.
	localparam word_t WORD_MAX = 16'h7FFF;
	localparam word_t WORD_MIN = 16'h8000;

endpackage

`default_nettype wire

//--- barrel_shifter.sv
`timescale 1ns/10ps
`default_nettype none

module barrel_shifter (
	input  wire alu_pkg::word_t   data,
	input  wire alu_pkg::shamt_t  shamt,
	input  wire alu_pkg::alu_op_t op,
	output alu_pkg::word_t        shifted
);

	import alu_pkg::*;

	// entry 0 of each chain is the unshifted word; entry k+1 is the output of stage k.
	word_t [SHAMT_W:0] left_st;
	word_t [SHAMT_W:0] right_st;

	logic sign_bit;
	logic sel_left;

	assign sign_bit = data[WORD_W-1]; // fill value for the right chain.

	assign left_st[0]  = data;
	assign right_st[0] = data;

	// stage k moves the word by 2**k places when shamt[k] is set.
	// Four stages of 1, 2, 4 and 8 cover every distance from 0 to 15.
	for (genvar k = 0; k < SHAMT_W; k++) begin : g_stage
		localparam int DIST = 1 << k;

		for (genvar i = 0; i < WORD_W; i++) begin : g_bit
			logic left_src;
			logic right_src;

			// left chain takes bit i-DIST, or zero below the shift distance.
			if (i >= DIST) begin : g_left_mid
				assign left_src = left_st[k][i-DIST];
			end else begin : g_left_fill
				assign left_src = 1'b0;
			end

			// right chain takes bit i+DIST, or the sign bit near the top.
			if (i + DIST < WORD_W) begin : g_right_mid
				assign right_src = right_st[k][i+DIST];
			end else begin : g_right_fill
				assign right_src = sign_bit;
			end

			// one 2:1 mux per bit and per chain.
			assign left_st[k+1][i]  = shamt[k] ? left_src : left_st[k][i];
			assign right_st[k+1][i] = shamt[k] ? right_src : right_st[k][i];
		end
	end

	// only OP_SLL goes left. Every other opcode reads the right chain, and the
	// result stage simply ignores the shifter output on add and subtract.
	assign sel_left = (op == OP_SLL);

	assign shifted = sel_left ? left_st[SHAMT_W] : right_st[SHAMT_W];

endmodule

`default_nettype wire

//--- sat_adder.sv
`timescale 1ns/10ps
`default_nettype none

module sat_adder (
	input  wire alu_pkg::word_t   a,
	input  wire alu_pkg::word_t   b,
	input  wire alu_pkg::alu_op_t op,
	output alu_pkg::word_t        sum,
	output logic                  ovf
);

	import alu_pkg::*;

	logic  do_sub;
	word_t b_eff;
	word_t carry_in;
	word_t raw_sum;
	logic  a_sign;
	logic  b_sign;
	logic  r_sign;

	// subtraction is a + ~b + 1, so one adder serves both opcodes.
	assign do_sub   = (op == OP_SUB);
	assign b_eff    = do_sub ? ~b : b;
	assign carry_in = {{(WORD_W-1){1'b0}}, do_sub};

	assign raw_sum = a + b_eff + carry_in; // carry out of the top bit is dropped.

	assign a_sign = a[WORD_W-1];
	assign b_sign = b_eff[WORD_W-1];
	assign r_sign = raw_sum[WORD_W-1];

	// Two's complement overflow needs operands of equal sign and a result of
	// the other sign. This holds for either carry in, so it covers the
	// subtract path with the inverted operand as well.
	assign ovf = (a_sign == b_sign) && (r_sign != a_sign);

	always_comb begin
		sum = raw_sum;
		if (ovf) begin
			// the true result has the sign of a, since both operands agreed on it.
			if (a_sign) begin
				sum = WORD_MIN;
			end else begin
				sum = WORD_MAX;
			end
		end
	end

endmodule

`default_nettype wire

//--- alu_result_stage.sv
`timescale 1ns/10ps
`default_nettype none

module alu_result_stage (
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   in_valid,
	input  wire alu_pkg::alu_op_t op,
	input  wire alu_pkg::word_t   shifted,
	input  wire alu_pkg::word_t   sum,
	input  wire                   ovf,
	output logic                  out_valid,
	output alu_pkg::word_t        result,
	output alu_pkg::flags_t       flags
);

	import alu_pkg::*;

	logic   is_shift;
	word_t  next_result;
	flags_t next_flags;

	assign is_shift = (op == OP_SLL) || (op == OP_SRA);

	// the two units run side by side, so the opcode picks one of them here.
	assign next_result = is_shift ? shifted : sum;

	always_comb begin
		next_flags = flags; // shifts keep N and V from the last arithmetic op.
		next_flags[FLAG_Z] = (next_result == '0);
		if (!is_shift) begin
			next_flags[FLAG_N] = sum[WORD_W-1];
			next_flags[FLAG_V] = ovf;
		end
	end

	// out_valid follows in_valid by one cycle, and with no back-pressure
	// every accepted operation leaves the stage on the next edge.
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// result and flags load only on a valid cycle and hold otherwise.
	always_ff @(posedge clk) begin
		if (rst) begin
			result <= '0;
			flags  <= '0;
		end else if (in_valid) begin
			result <= next_result;
			flags  <= next_flags;
		end
	end

endmodule

`default_nettype wire

//--- alu_exec.sv
`timescale 1ns/10ps
`default_nettype none

module alu_exec (
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   in_valid,
	input  wire alu_pkg::alu_op_t op,
	input  wire alu_pkg::word_t   a,
	input  wire alu_pkg::word_t   b,
	input  wire alu_pkg::shamt_t  shamt,
	output logic                  out_valid,
	output alu_pkg::word_t        result,
	output alu_pkg::flags_t       flags
);

	import alu_pkg::*;

	word_t shifted; // shifter output, valid in the same cycle as the inputs.
	word_t sum;     // saturated add or subtract.
	logic  ovf;

	// both units see every operation. Only one of them is picked later.
	barrel_shifter shifter_i (
		.data    (a),
		.shamt   (shamt),
		.op      (op),
		.shifted (shifted)
	);

	sat_adder adder_i (
		.a   (a),
		.b   (b),
		.op  (op),
		.sum (sum),
		.ovf (ovf)
	);

	// the only register stage of the block.
	alu_result_stage result_i (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.op        (op),
		.shifted   (shifted),
		.sum       (sum),
		.ovf       (ovf),
		.out_valid (out_valid),
		.result    (result),
		.flags     (flags)
	);

endmodule

`default_nettype wire

//--- alu_exec_tb.sv
`timescale 1ns/10ps
`default_nettype none

module alu_exec_tb;

	import alu_pkg::*;

	logic     clk;
	logic     rst;
	logic     in_valid;
	alu_op_t  op;
	word_t    a;
	word_t    b;
	shamt_t   shamt;
	logic     out_valid;
	word_t    result;
	flags_t   flags;

	logic [31:0] lfsr_state;

	// the reference model state is updated at the edge where an operation is accepted.
	logic   exp_valid;
	word_t  exp_result;
	flags_t exp_flags;
	logic   primed = 1'b0;

	int errors   = 0;
	int checks   = 0;
	int accepted = 0;
	int seen     = 0;

	alu_exec dut_i (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.op        (op),
		.a         (a),
		.b         (b),
		.shamt     (shamt),
		.out_valid (out_valid),
		.result    (result),
		.flags     (flags)
	);

	always #20 clk = ~clk;

	// galois form with taps for x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	// one LFSR step per bit taken.
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v[i] = lfsr_state[0];
		end
		return v;
	endfunction

	// bit i of a left shift comes from bit i-s, of a right shift from bit i+s or the sign.
	function automatic word_t shift_model(input alu_op_t o, input word_t d, input shamt_t s);
		word_t r;
		int i;
		int k;
		k = int'(s);
		for (i = 0; i < 16; i++) begin
			if (o == OP_SLL) begin
				r[i] = (i >= k) ? d[i - k] : 1'b0;
			end else begin
				r[i] = (i + k <= 15) ? d[i + k] : d[15];
			end
		end
		return r;
	endfunction

	// returns {overflow, clamped result} as computed on the full integer range.
	function automatic logic [16:0] sat_model(input alu_op_t o, input word_t x, input word_t y);
		int t;
		logic v;
		word_t r;
		if (o == OP_SUB) begin
			t = int'($signed(x)) - int'($signed(y));
		end else begin
			t = int'($signed(x)) + int'($signed(y));
		end
		if (t > 32767) begin
			r = 16'h7FFF;
			v = 1'b1;
		end else if (t < -32768) begin
			r = 16'h8000;
			v = 1'b1;
		end else begin
			r = t[15:0];
			v = 1'b0;
		end
		return {v, r};
	endfunction

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		checks++;
		assert (actual === expected) else begin
			$display("mismatch %s: expected %h, got %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic drive_op(input logic v, input alu_op_t o, input word_t x, input word_t y,
			input shamt_t s);
		@(posedge clk);
		in_valid <= v;
		op       <= o;
		a        <= x;
		b        <= y;
		shamt    <= s;
	endtask

	task automatic drive_idle();
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	// returns the number of the cycle that showed out_valid, or 0 on timeout.
	task automatic wait_for_out_valid(output int waited);
		int i;
		waited = 0;
		for (i = 1; i <= 4 && waited == 0; i++) begin
			@(negedge clk);
			if (out_valid === 1'b1) begin
				waited = i;
			end
		end
		assert (waited != 0) else begin
			$display("timeout: out_valid never came within 4 cycles");
			errors++;
		end
	endtask

	// random operands with a corner value forced now and then.
	task automatic drive_random_op(input logic v);
		logic [31:0] r_op;
		logic [31:0] r_a;
		logic [31:0] r_b;
		logic [31:0] r_sh;
		logic [31:0] corner;
		word_t x;
		word_t y;
		shamt_t s;
		r_op   = take_bits(2);
		r_a    = take_bits(16);
		r_b    = take_bits(16);
		r_sh   = take_bits(4);
		corner = take_bits(3);
		x = r_a[15:0];
		y = r_b[15:0];
		s = r_sh[3:0];
		case (corner[2:0])
			3'd0: s = 4'd0;
			3'd1: s = 4'd15;
			3'd2: x = 16'h7FFF;
			3'd3: x = 16'h8000;
			3'd4: y = 16'h0000;
			default: ;
		endcase
		drive_op(v, r_op[1:0], x, y, s);
	endtask

	// one isolated operation with values worked out by hand. flags read {N, V, Z}.
	task automatic run_single(input alu_op_t o, input word_t x, input word_t y,
			input shamt_t s, input word_t want_result, input flags_t want_flags);
		int waited;
		drive_op(1'b1, o, x, y, s);
		drive_idle();
		wait_for_out_valid(waited);
		if (waited != 0) begin
			check_value("result", want_result, result);
			check_value("flags", {13'b0, want_flags}, {13'b0, flags});
		end
	endtask

	task automatic run_burst(input int len);
		int i;
		int waited;
		word_t held_result;
		flags_t held_flags;
		drive_random_op(1'b1);
		for (i = 1; i <= len; i++) begin
			if (i < len) begin
				drive_random_op(1'b1);
			end else begin
				drive_idle();
			end
			wait_for_out_valid(waited);
			assert (waited == 1) else begin
				$display("out_valid was not high on consecutive cycles in a burst");
				errors++;
			end
		end
		held_result = exp_result;
		held_flags  = exp_flags;
		@(negedge clk); // the idle input cycle reaches the outputs here.
		check_value("out_valid", 16'h0000, {15'b0, out_valid});
		check_value("result", held_result, result);
		check_value("flags", {13'b0, held_flags}, {13'b0, flags});
	endtask

	always @(posedge clk) begin : model_update
		logic [16:0] sat_out;
		if (rst) begin
			exp_valid  = 1'b0;
			exp_result = '0;
			exp_flags  = '0;
		end else begin
			exp_valid = in_valid;
			if (in_valid) begin
				accepted++;
				if (op == OP_SLL || op == OP_SRA) begin
					exp_result = shift_model(op, a, shamt); // N and V stay as they are.
				end else begin
					sat_out = sat_model(op, a, b);
					exp_result = sat_out[15:0];
					exp_flags[FLAG_V] = sat_out[16];
					exp_flags[FLAG_N] = sat_out[15];
				end
				exp_flags[FLAG_Z] = (exp_result == 16'h0000);
			end
		end
		primed = 1'b1;
	end

	// outputs settle after the rising edge, so they are compared at the falling edge.
	always @(negedge clk) begin
		if (primed) begin
			check_value("out_valid", {15'b0, exp_valid}, {15'b0, out_valid});
			check_value("result", exp_result, result);
			check_value("flags", {13'b0, exp_flags}, {13'b0, flags});
			if (out_valid === 1'b1) begin
				seen++;
			end
		end
	end

	initial begin
		int n;
		int s;
		int waited;
		logic [31:0] r_a;
		logic [31:0] r_b;
		logic [31:0] r_v;
		clk        = 1'b0;
		rst        = 1'b1;
		in_valid   = 1'b0;
		op         = OP_ADD;
		a          = '0;
		b          = '0;
		shamt      = '0;
		lfsr_state = 32'h610;

		repeat (5) @(posedge clk);
		rst <= 1'b0;

		// nothing has been issued yet, so every output is still cleared.
		@(negedge clk);
		check_value("out_valid", 16'h0000, {15'b0, out_valid});
		check_value("result", 16'h0000, result);
		check_value("flags", 16'h0000, {13'b0, flags});
		repeat (2) @(negedge clk);

		// saturation in both directions and shifts that keep N and V.
		run_single(OP_SUB, 16'h8000, 16'h0001, 4'd0, 16'h8000, 3'b110);
		run_single(OP_SLL, 16'h0000, 16'h1234, 4'd3, 16'h0000, 3'b111);
		run_single(OP_SRA, 16'h8000, 16'h0000, 4'd15, 16'hFFFF, 3'b110);
		run_single(OP_ADD, 16'h7FFF, 16'h0001, 4'd0, 16'h7FFF, 3'b010);
		run_single(OP_SLL, 16'h0001, 16'h0000, 4'd15, 16'h8000, 3'b010);
		run_single(OP_ADD, 16'h1234, 16'hEDCC, 4'd0, 16'h0000, 3'b001);
		run_single(OP_SUB, 16'h7FFF, 16'h0000, 4'd0, 16'h7FFF, 3'b000);
		run_single(OP_SRA, 16'h4000, 16'h0000, 4'd14, 16'h0001, 3'b000);

		// every shift amount in both directions goes in back to back.
		for (s = 0; s < 16; s++) begin
			r_a = take_bits(16);
			r_b = take_bits(16);
			drive_op(1'b1, OP_SLL, r_a[15:0], r_b[15:0], s[3:0]);
			r_a = take_bits(16);
			if (s[0]) begin
				r_a[15] = 1'b1; // odd amounts shift a negative word.
			end
			drive_op(1'b1, OP_SRA, r_a[15:0], r_b[15:0], s[3:0]);
		end
		drive_idle();
		wait_for_out_valid(waited);

		run_burst(4);
		run_burst(6);

		// a random stream leaves in_valid low about one cycle in four.
		for (n = 0; n < 500; n++) begin
			r_v = take_bits(2);
			drive_random_op(r_v[1:0] != 2'b00);
		end
		drive_idle();
		repeat (2) @(negedge clk);

		assert (accepted == seen) else begin
			$display("%0d operations were accepted but %0d results came out", accepted, seen);
			errors++;
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- alu_exec.f
alu_pkg.sv
barrel_shifter.sv
sat_adder.sv
alu_result_stage.sv
alu_exec.sv
alu_exec_tb.sv
